// File: build.f
common/processorci_pkg.sv
controller/uart_link.sv
controller/host_cmd.sv
design/wb_memory.sv
design/core_bridge.sv
design/processorci_top.sv
sim/tb_processorci.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_processorci
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_processorci.sv
`timescale 1ns/1ps

module tb_processorci;
  import processorci_pkg::*;

  localparam int RX_TIMEOUT   = 2000; // Cycles to wait for a reply start bit
  localparam int CORE_TIMEOUT = 50;

  logic       clk = 1'b0;
  logic       rst;
  logic       rx;
  logic       tx;
  logic       core_rst;
  core_req_t  instr_req, data_req;
  core_rsp_t  instr_rsp, data_rsp;

  logic [31:0] lfsr_q = 32'd91284;
  logic [7:0]  cmd_bytes[$];   // Frame for the next host command
  string       test_name;

  processorci_top dut (
    .sys_clk(clk), .rst_i(rst), .rx_i(rx), .tx_o(tx), .core_rst_o(core_rst),
    .instr_req_i(instr_req), .instr_rsp_o(instr_rsp),
    .data_req_i(data_req), .data_rsp_o(data_rsp)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s (%s): expected %h, actual %h", test_name, what, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout in %s: %s", test_name, what);
    $display("=== FAIL ===");
    $fatal(1, "stopping on timeout");
  endtask

  // Right-shift Galois form stepped once per bit
  function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
  endfunction

  task automatic random_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      w[i]   = lfsr_q[0];
      lfsr_q = lfsr_advance(lfsr_q);
    end
  endtask

  task automatic uart_send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0}; // Stop, data LSB first, start
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rx <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic uart_recv_byte(output logic [7:0] b);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (tx !== 1'b0 && waited < RX_TIMEOUT);
    if (tx !== 1'b0) stop_on_timeout("no start bit on tx_o");
    repeat (CLKS_PER_BIT / 2) @(negedge clk); // Middle of start bit
    check_value("start bit", 32'd0, 32'(tx));
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      b[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    check_value("stop bit", 32'd1, 32'(tx));
  endtask

  // Reply can start before the last stop bit ends, so listen in parallel
  task automatic host_exchange(input int n_reply, output logic [31:0] reply);
    logic [7:0] b;
    reply = '0;
    fork
      begin
        foreach (cmd_bytes[i]) uart_send_byte(cmd_bytes[i]);
      end
      begin
        for (int k = 0; k < n_reply; k++) begin
          uart_recv_byte(b);
          reply[8*k +: 8] = b;
        end
      end
    join
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] reply;
    cmd_bytes.delete();
    cmd_bytes.push_back(8'h57);
    for (int i = 0; i < 4; i++) cmd_bytes.push_back(addr[8*i +: 8]);
    for (int i = 0; i < 4; i++) cmd_bytes.push_back(data[8*i +: 8]);
    host_exchange(1, reply);
    check_value("WRITE reply", 32'(REPLY_ACK), reply);
  endtask

  task automatic host_read(input logic [31:0] addr, output logic [31:0] data);
    cmd_bytes.delete();
    cmd_bytes.push_back(8'h52);
    for (int i = 0; i < 4; i++) cmd_bytes.push_back(addr[8*i +: 8]);
    host_exchange(4, data);
  endtask

  task automatic host_command(input logic [7:0] op, input logic [7:0] expected);
    logic [31:0] reply;
    cmd_bytes.delete();
    cmd_bytes.push_back(op);
    host_exchange(1, reply);
    check_value("single byte reply", 32'(expected), reply);
  endtask

  // One core transfer with gnt alongside req and rvalid 3 quiet cycles later
  task automatic core_access(input bit use_data, input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int        latency;
    core_rsp_t rsp;
    @(posedge clk);
    if (use_data) data_req <= '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    else          instr_req <= '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    @(negedge clk);
    rsp = use_data ? data_rsp : instr_rsp;
    check_value("gnt with req", 32'd1, 32'(rsp.gnt));
    @(posedge clk);
    if (use_data) data_req <= '0;
    else          instr_req <= '0;
    latency = 0;
    do begin
      @(negedge clk);
      latency++;
      rsp = use_data ? data_rsp : instr_rsp;
    end while (!rsp.rvalid && latency < CORE_TIMEOUT);
    if (!rsp.rvalid) stop_on_timeout("no rvalid from the core bridge");
    check_value("rvalid latency", 32'd3, 32'(latency));
    rdata = rsp.rdata;
  endtask

  task automatic test_reset_state;
    test_name = "reset_state";
    repeat (5) begin
      @(negedge clk);
      check_value("core_rst_o", 32'd1, 32'(core_rst));
      check_value("tx_o idle", 32'd1, 32'(tx));
      check_value("instr gnt", 32'd0, 32'(instr_rsp.gnt));
      check_value("instr rvalid", 32'd0, 32'(instr_rsp.rvalid));
      check_value("data gnt", 32'd0, 32'(data_rsp.gnt));
      check_value("data rvalid", 32'd0, 32'(data_rsp.rvalid));
    end
  endtask

  task automatic test_host_memory;
    logic [31:0] offs[4] = '{32'h0000, 32'h0004, 32'h0200, 32'h0FFC};
    logic [31:0] imem_exp[4];
    logic [31:0] dmem_exp[4];
    logic [31:0] got;
    test_name = "host_memory";
    for (int i = 0; i < 4; i++) begin
      random_word(imem_exp[i]);
      random_word(dmem_exp[i]);
      host_write(offs[i], imem_exp[i]);
      host_write(offs[i] | (32'd1 << MEM_SEL_BIT), dmem_exp[i]); // Same offset in data memory
    end
    for (int i = 0; i < 4; i++) begin
      host_read(offs[i], got);
      check_value("imem readback", imem_exp[i], got);
      host_read(offs[i] | (32'd1 << MEM_SEL_BIT), got);
      check_value("dmem readback", dmem_exp[i], got);
    end
  endtask

  task automatic test_run_halt;
    logic [31:0] word;
    logic [31:0] got;
    test_name = "run_halt";
    host_command(8'h53, REPLY_ACK);
    check_value("core_rst_o after RUN", 32'd0, 32'(core_rst));
    host_command(8'h48, REPLY_ACK);
    check_value("core_rst_o after HALT", 32'd1, 32'(core_rst));
    random_word(word);
    host_write(32'h0000_0010, word);
    host_command(8'hA5, REPLY_NAK);
    host_read(32'h0000_0010, got);
    check_value("READ after NAK", word, got);
  endtask

  task automatic test_core_fetch;
    logic [31:0] word;
    logic [31:0] got;
    test_name = "core_fetch";
    random_word(word);
    host_write(32'h0000_0040, word);
    core_access(1'b0, 1'b0, 32'h0000_0040, 32'h0, got);
    check_value("fetched word", word, got);
  endtask

  task automatic test_core_data;
    logic [31:0] iword;
    logic [31:0] dword;
    logic [31:0] got;
    test_name = "core_data";
    random_word(iword);
    random_word(dword);
    host_write(32'h0000_0080, iword);
    core_access(1'b1, 1'b1, 32'h0000_0080, dword, got); // Store
    core_access(1'b1, 1'b0, 32'h0000_0080, 32'h0, got); // Load back
    check_value("core load", dword, got);
    host_read(32'h0000_0080 | (32'd1 << MEM_SEL_BIT), got);
    check_value("host read of dmem", dword, got);
    host_read(32'h0000_0080, got);
    check_value("imem untouched", iword, got);
  endtask

  initial begin
    rst       = 1'b1;
    rx        = 1'b1;
    instr_req = '0;
    data_req  = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_reset_state();
    test_host_memory();
    test_run_halt();
    test_core_fetch();
    test_core_data();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: design/processorci_top.sv
`timescale 1ns/1ps

module processorci_top (
  input  logic                       sys_clk,
  input  logic                       rst_i,
  input  logic                       rx_i,
  output logic                       tx_o,
  output logic                       core_rst_o,
  input  processorci_pkg::core_req_t instr_req_i,
  output processorci_pkg::core_rsp_t instr_rsp_o,
  input  processorci_pkg::core_req_t data_req_i,
  output processorci_pkg::core_rsp_t data_rsp_o
);
  import processorci_pkg::*;

  logic [7:0]    rx_byte;
  logic          rx_valid;
  logic [7:0]    tx_byte;
  logic          tx_valid;
  logic          tx_ready;
  host_mem_req_t imem_host_req, dmem_host_req;
  logic [31:0]   imem_host_rdata, dmem_host_rdata;
  wb_req_t       imem_wb_req, dmem_wb_req;
  wb_rsp_t       imem_wb_rsp, dmem_wb_rsp;

  uart_link u_uart (
    .clk(sys_clk), .rst_i(rst_i), .rx_i(rx_i), .tx_o(tx_o),
    .rx_byte_o(rx_byte), .rx_valid_o(rx_valid),
    .tx_byte_i(tx_byte), .tx_valid_i(tx_valid), .tx_ready_o(tx_ready)
  );

  host_cmd u_host_cmd (
    .clk(sys_clk), .rst_i(rst_i), .rx_byte_i(rx_byte), .rx_valid_i(rx_valid),
    .tx_byte_o(tx_byte), .tx_valid_o(tx_valid), .tx_ready_i(tx_ready),
    .imem_req_o(imem_host_req), .dmem_req_o(dmem_host_req),
    .imem_rdata_i(imem_host_rdata), .dmem_rdata_i(dmem_host_rdata),
    .core_rst_o(core_rst_o)
  );

  // Instruction side
  core_bridge u_instr_bridge (
    .clk(sys_clk), .rst_i(rst_i), .core_req_i(instr_req_i), .core_rsp_o(instr_rsp_o),
    .wb_req_o(imem_wb_req), .wb_rsp_i(imem_wb_rsp)
  );
  wb_memory u_imem (
    .clk(sys_clk), .rst_i(rst_i), .wb_req_i(imem_wb_req), .wb_rsp_o(imem_wb_rsp),
    .host_req_i(imem_host_req), .host_rdata_o(imem_host_rdata)
  );

  // Data side
  core_bridge u_data_bridge (
    .clk(sys_clk), .rst_i(rst_i), .core_req_i(data_req_i), .core_rsp_o(data_rsp_o),
    .wb_req_o(dmem_wb_req), .wb_rsp_i(dmem_wb_rsp)
  );
  wb_memory u_dmem (
    .clk(sys_clk), .rst_i(rst_i), .wb_req_i(dmem_wb_req), .wb_rsp_o(dmem_wb_rsp),
    .host_req_i(dmem_host_req), .host_rdata_o(dmem_host_rdata)
  );

endmodule

// File: design/core_bridge.sv
`timescale 1ns/1ps

module core_bridge (
  input  logic                       clk,
  input  logic                       rst_i,
  input  processorci_pkg::core_req_t core_req_i,
  output processorci_pkg::core_rsp_t core_rsp_o,
  output processorci_pkg::wb_req_t   wb_req_o,
  input  processorci_pkg::wb_rsp_t   wb_rsp_i
);
  import processorci_pkg::*;

  bridge_state_e state_q;
  logic          we_q;
  logic [31:0]   addr_q;
  logic [31:0]   wdata_q;
  logic [31:0]   rdata_q;
  logic          take;

  assign take = (state_q == IDLE) && core_req_i.req; // Grant only when idle

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (take) state_q <= BUS;
        BUS:     if (wb_rsp_i.ack) state_q <= DONE;
        DONE:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      we_q    <= core_req_i.we;
      addr_q  <= core_req_i.addr;
      wdata_q <= core_req_i.wdata;
    end
    if (state_q == BUS && wb_rsp_i.ack) rdata_q <= wb_rsp_i.dat;
  end

  assign core_rsp_o.gnt    = take;
  assign core_rsp_o.rvalid = (state_q == DONE);
  assign core_rsp_o.rdata  = rdata_q;

  assign wb_req_o.cyc = (state_q == BUS);
  assign wb_req_o.stb = (state_q == BUS);
  assign wb_req_o.we  = we_q;
  assign wb_req_o.adr = addr_q;
  assign wb_req_o.dat = wdata_q;

endmodule

// File: design/wb_memory.sv
`timescale 1ns/1ps

module wb_memory (
  input  logic                           clk,
  input  logic                           rst_i,
  input  processorci_pkg::wb_req_t       wb_req_i,
  output processorci_pkg::wb_rsp_t       wb_rsp_o,
  input  processorci_pkg::host_mem_req_t host_req_i,
  output logic [31:0]                    host_rdata_o
);
  import processorci_pkg::*;

  logic [31:0]       mem_q [MEM_WORDS];
  logic [31:0]       rd_q;     // Shared read register
  logic              ack_q;
  logic              wb_serve;
  logic              access;
  logic              we;
  logic [MEM_AW-1:0] addr;
  logic [31:0]       wdata;

  // Host wins the port; a cycle already acked is not served twice
  assign wb_serve = wb_req_i.cyc && wb_req_i.stb && !ack_q && !host_req_i.valid;
  assign access   = host_req_i.valid || wb_serve;

  always_comb begin
    if (host_req_i.valid) begin
      addr  = host_req_i.addr;
      we    = host_req_i.we;
      wdata = host_req_i.wdata;
    end else begin
      addr  = wb_req_i.adr[MEM_AW+1:2]; // Word address from byte address
      we    = wb_req_i.we;
      wdata = wb_req_i.dat;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (we) mem_q[addr] <= wdata;
      rd_q <= mem_q[addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) ack_q <= 1'b0;
    else       ack_q <= wb_serve;
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rd_q;
  assign host_rdata_o = rd_q;

endmodule

// File: controller/host_cmd.sv
`timescale 1ns/1ps

module host_cmd (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic [7:0]                    rx_byte_i,
  input  logic                          rx_valid_i,
  output logic [7:0]                    tx_byte_o,
  output logic                          tx_valid_o,
  input  logic                          tx_ready_i,
  output processorci_pkg::host_mem_req_t imem_req_o,
  output processorci_pkg::host_mem_req_t dmem_req_o,
  input  logic [31:0]                   imem_rdata_i,
  input  logic [31:0]                   dmem_rdata_i,
  output logic                          core_rst_o
);
  import processorci_pkg::*;

  cmd_state_e    state_q;
  host_cmd_e     op_q;
  logic [31:0]   addr_q;
  logic [31:0]   wdata_q;
  logic [31:0]   reply_q;     // Sent low byte first
  logic [1:0]    byte_cnt_q;
  logic [2:0]    reply_cnt_q;
  logic          core_rst_q;
  logic          sel_dmem;
  host_mem_req_t mem_req;

  assign sel_dmem = addr_q[MEM_SEL_BIT];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= WAIT_OP;
      byte_cnt_q  <= '0;
      reply_cnt_q <= '0;
      core_rst_q  <= 1'b1; // Core held until RUN
    end else begin
      case (state_q)
        WAIT_OP: begin
          if (rx_valid_i) begin
            op_q       <= host_cmd_e'(rx_byte_i);
            byte_cnt_q <= '0;
            case (host_cmd_e'(rx_byte_i))
              CMD_WRITE, CMD_READ: state_q <= GET_ADDR;
              CMD_RUN, CMD_HALT: begin
                core_rst_q  <= (host_cmd_e'(rx_byte_i) == CMD_HALT);
                reply_q     <= {24'b0, REPLY_ACK};
                reply_cnt_q <= 3'd1;
                state_q     <= SEND_REPLY;
              end
              default: begin
                reply_q     <= {24'b0, REPLY_NAK};
                reply_cnt_q <= 3'd1;
                state_q     <= SEND_REPLY;
              end
            endcase
          end
        end
        GET_ADDR: begin
          if (rx_valid_i) begin
            addr_q     <= {rx_byte_i, addr_q[31:8]}; // Little-endian
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == 2'd3) begin
              state_q <= (op_q == CMD_WRITE) ? GET_DATA : MEM_ACCESS;
            end
          end
        end
        GET_DATA: begin
          if (rx_valid_i) begin
            wdata_q    <= {rx_byte_i, wdata_q[31:8]};
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == 2'd3) state_q <= MEM_ACCESS;
          end
        end
        MEM_ACCESS: begin
          if (op_q == CMD_WRITE) begin
            reply_q     <= {24'b0, REPLY_ACK};
            reply_cnt_q <= 3'd1;
            state_q     <= SEND_REPLY;
          end else begin
            state_q <= MEM_READ;
          end
        end
        MEM_READ: begin
          reply_q     <= sel_dmem ? dmem_rdata_i : imem_rdata_i;
          reply_cnt_q <= 3'd4;
          state_q     <= SEND_REPLY;
        end
        SEND_REPLY: begin
          if (tx_ready_i) begin
            reply_q     <= {8'b0, reply_q[31:8]};
            reply_cnt_q <= reply_cnt_q - 1'b1;
            if (reply_cnt_q == 3'd1) state_q <= WAIT_OP;
          end
        end
        default: state_q <= WAIT_OP;
      endcase
    end
  end

  // One access per command steered by the select bit
  always_comb begin
    mem_req.valid = (state_q == MEM_ACCESS);
    mem_req.we    = (op_q == CMD_WRITE);
    mem_req.addr  = addr_q[MEM_AW+1:2];
    mem_req.wdata = wdata_q;
    imem_req_o       = mem_req;
    dmem_req_o       = mem_req;
    imem_req_o.valid = mem_req.valid && !sel_dmem;
    dmem_req_o.valid = mem_req.valid && sel_dmem;
  end

  assign tx_byte_o  = reply_q[7:0];
  assign tx_valid_o = (state_q == SEND_REPLY);
  assign core_rst_o = core_rst_q;

endmodule

// File: controller/uart_link.sv
`timescale 1ns/1ps

module uart_link (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       rx_i,
  output logic       tx_o,
  output logic [7:0] rx_byte_o,
  output logic       rx_valid_o,
  input  logic [7:0] tx_byte_i,
  input  logic       tx_valid_i,
  output logic       tx_ready_o
);
  import processorci_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e             rx_state_q;
  logic [1:0]            rx_sync_q;  // Bit 1 is the synchronised line
  logic [UART_CNT_W-1:0] rx_cnt_q;
  logic [2:0]            rx_bit_q;
  logic [7:0]            rx_shift_q;
  logic                  rx_valid_q;

  logic [9:0]            tx_shift_q; // Stop, data, start
  logic [3:0]            tx_bits_q;  // Bits left on the line
  logic [UART_CNT_W-1:0] tx_cnt_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_sync_q  <= 2'b11;
      rx_state_q <= RX_IDLE;
      rx_cnt_q   <= '0;
      rx_bit_q   <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_sync_q  <= {rx_sync_q[0], rx_i};
      rx_valid_q <= 1'b0;
      case (rx_state_q)
        RX_IDLE: begin
          rx_cnt_q <= '0;
          if (!rx_sync_q[1]) rx_state_q <= RX_START;
        end
        RX_START: begin
          if (rx_cnt_q == UART_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            rx_cnt_q   <= '0;
            rx_bit_q   <= '0;
            rx_state_q <= rx_sync_q[1] ? RX_IDLE : RX_DATA; // Back to idle on a glitch
          end else begin
            rx_cnt_q <= rx_cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (rx_cnt_q == UART_CNT_W'(CLKS_PER_BIT - 1)) begin
            rx_cnt_q   <= '0;
            rx_shift_q <= {rx_sync_q[1], rx_shift_q[7:1]}; // LSB first
            rx_bit_q   <= rx_bit_q + 1'b1;
            if (rx_bit_q == 3'd7) rx_state_q <= RX_STOP;
          end else begin
            rx_cnt_q <= rx_cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (rx_cnt_q == UART_CNT_W'(CLKS_PER_BIT - 1)) begin
            rx_state_q <= RX_IDLE;
            rx_valid_q <= rx_sync_q[1]; // Drop frames with a bad stop bit
          end else begin
            rx_cnt_q <= rx_cnt_q + 1'b1;
          end
        end
        default: rx_state_q <= RX_IDLE;
      endcase
    end
  end

  assign rx_byte_o  = rx_shift_q;
  assign rx_valid_o = rx_valid_q;

  assign tx_ready_o = (tx_bits_q == 4'd0);
  assign tx_o       = tx_shift_q[0];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      tx_shift_q <= '1;
      tx_bits_q  <= '0;
      tx_cnt_q   <= '0;
    end else if (tx_valid_i && tx_ready_o) begin
      tx_shift_q <= {1'b1, tx_byte_i, 1'b0};
      tx_bits_q  <= 4'd10;
      tx_cnt_q   <= '0;
    end else if (tx_bits_q != 4'd0) begin
      if (tx_cnt_q == UART_CNT_W'(CLKS_PER_BIT - 1)) begin
        tx_cnt_q   <= '0;
        tx_shift_q <= {1'b1, tx_shift_q[9:1]}; // Idle high once drained
        tx_bits_q  <= tx_bits_q - 1'b1;
      end else begin
        tx_cnt_q <= tx_cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: common/processorci_pkg.sv
package processorci_pkg;

  // Short UART bit time for simulation
  localparam int CLKS_PER_BIT = 8;
  localparam int UART_CNT_W   = $clog2(CLKS_PER_BIT);

  // Memory geometry
  localparam int MEM_WORDS   = 1024;
  localparam int MEM_AW      = 10;
  localparam int MEM_SEL_BIT = 16; // Set selects data memory

  localparam logic [7:0] REPLY_ACK = 8'h06;
  localparam logic [7:0] REPLY_NAK = 8'h15;

  // Core side req/gnt/rvalid
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;  // Byte address
    logic [31:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } core_rsp_t;

  // Wishbone classic
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic              valid;
    logic              we;
    logic [MEM_AW-1:0] addr; // Word address
    logic [31:0]       wdata;
  } host_mem_req_t;

  typedef enum logic [7:0] {
    CMD_WRITE = 8'h57,
    CMD_READ  = 8'h52,
    CMD_RUN   = 8'h53,
    CMD_HALT  = 8'h48
  } host_cmd_e;

  typedef enum logic [2:0] {
    WAIT_OP,
    GET_ADDR,
    GET_DATA,
    MEM_ACCESS,
    MEM_READ,
    SEND_REPLY
  } cmd_state_e;

  typedef enum logic [1:0] {
    IDLE,
    BUS,
    DONE
  } bridge_state_e;

endpackage
